/* src/uart_pkg.sv */
package uart_pkg;

    // Parity mode of a frame
    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } uart_parity_e;

    // Decoded configuration, divisor in the low half word
    typedef struct packed {
        logic [12:0]  reserved;
        logic         stop_two;
        uart_parity_e parity;
        logic [15:0]  divisor;
    } uart_fields_t;

    // Same word seen as bus lanes or as fields
    typedef union packed {
        logic [31:0]  raw;
        uart_fields_t fields;
    } uart_config_u;

    // Wishbone classic request from the master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone classic response from the slave
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Word addresses
    localparam logic [1:0] ADDR_CONFIG        = 2'd0;
    localparam logic [1:0] ADDR_RXDATA        = 2'd1;
    localparam logic [1:0] ADDR_TXDATA_STATUS = 2'd2;

    // Bit positions in the status word
    localparam int STATUS_RX_EMPTY   = 0;
    localparam int STATUS_TX_FULL    = 1;
    localparam int STATUS_PARITY_ERR = 2;

endpackage

/* src/uart_fifo.sv */
`timescale 1ns/100ps

module uart_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  wr_en_i,
    input  logic [DATA_WIDTH-1:0] wr_data_i,
    input  logic                  rd_en_i,
    output logic [DATA_WIDTH-1:0] rd_data_o,
    output logic                  rd_valid_o,
    output logic                  empty_o,
    output logic                  full_o
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Extra MSB tells a wrapped writer from an equal position
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic                do_write;
    logic                do_read;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                     (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign do_write = wr_en_i && !full_o;
    assign do_read  = rd_en_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_data_i;
        end
        if (do_read) begin
            rd_data_o <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Valid only for a pop that found data
            rd_valid_o <= do_read;
        end
    end

endmodule

/* src/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  uart_pkg::uart_fields_t config_i,
    input  logic                  rxd_i,
    output logic [7:0]            byte_o,
    output logic                  byte_valid_o,
    output logic                  parity_err_o
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    rx_state_e              state_r;
    logic                   rxd_meta_r;
    logic                   rxd_sync_r;
    logic                   rxd_prev_r;
    logic [15:0]            cnt_r;
    logic [15:0]            divisor_r;
    uart_pkg::uart_parity_e parity_r;
    logic [2:0]             bit_idx_r;
    logic [7:0]             shift_r;
    logic                   par_bad_r;
    logic                   sample_w;

    assign sample_w = (cnt_r == 16'd0);
    assign byte_o   = shift_r;

    // Two flop synchronizer, line idles high
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rxd_meta_r <= 1'b1;
            rxd_sync_r <= 1'b1;
            rxd_prev_r <= 1'b1;
        end else begin
            rxd_meta_r <= rxd_i;
            rxd_sync_r <= rxd_meta_r;
            rxd_prev_r <= rxd_sync_r;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_r      <= RX_IDLE;
            cnt_r        <= '0;
            divisor_r    <= '0;
            parity_r     <= uart_pkg::PARITY_NONE;
            bit_idx_r    <= '0;
            shift_r      <= '0;
            par_bad_r    <= 1'b0;
            byte_valid_o <= 1'b0;
            parity_err_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            parity_err_o <= 1'b0;
            if (state_r != RX_IDLE && !sample_w) begin
                cnt_r <= cnt_r - 16'd1;
            end
            case (state_r)
                RX_IDLE: begin
                    if (rxd_prev_r && !rxd_sync_r) begin
                        divisor_r <= config_i.divisor;
                        parity_r  <= config_i.parity;
                        cnt_r     <= config_i.divisor >> 1;
                        par_bad_r <= 1'b0;
                        state_r   <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample_w) begin
                        // High at mid-bit means a glitch, not a start bit
                        if (!rxd_sync_r) begin
                            cnt_r     <= divisor_r - 16'd1;
                            bit_idx_r <= '0;
                            state_r   <= RX_DATA;
                        end else begin
                            state_r <= RX_IDLE;
                        end
                    end
                end
                RX_DATA: begin
                    if (sample_w) begin
                        shift_r   <= {rxd_sync_r, shift_r[7:1]};
                        cnt_r     <= divisor_r - 16'd1;
                        bit_idx_r <= bit_idx_r + 3'd1;
                        if (bit_idx_r == 3'd7) begin
                            state_r <= (parity_r == uart_pkg::PARITY_NONE) ? RX_STOP : RX_PARITY;
                        end
                    end
                end
                RX_PARITY: begin
                    if (sample_w) begin
                        par_bad_r <= ((^shift_r) ^ rxd_sync_r) != (parity_r == uart_pkg::PARITY_ODD);
                        cnt_r     <= divisor_r - 16'd1;
                        state_r   <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    // Middle of the first stop bit
                    if (sample_w) begin
                        byte_valid_o <= !par_bad_r;
                        parity_err_o <= par_bad_r;
                        state_r      <= RX_IDLE;
                    end
                end
                default: state_r <= RX_IDLE;
            endcase
        end
    end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  uart_pkg::uart_fields_t config_i,
    output logic                  rd_en_o,
    input  logic [7:0]            rd_data_i,
    input  logic                  rd_valid_i,
    output logic                  txd_o
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    tx_state_e    state_r;
    uart_pkg::uart_fields_t cfg_r;
    logic [15:0]  cnt_r;
    logic [2:0]   bit_idx_r;
    logic [7:0]   shift_r;
    logic         par_bit_r;
    logic         second_stop_r;
    logic         bit_end_w;

    assign bit_end_w = (cnt_r == 16'd0);

    // Ask for a byte while idle, but not while one is arriving
    assign rd_en_o = (state_r == TX_IDLE) && !rd_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_r       <= TX_IDLE;
            cfg_r         <= '0;
            cnt_r         <= '0;
            bit_idx_r     <= '0;
            shift_r       <= '0;
            par_bit_r     <= 1'b0;
            second_stop_r <= 1'b0;
            txd_o         <= 1'b1;
        end else begin
            if (state_r != TX_IDLE && !bit_end_w) begin
                cnt_r <= cnt_r - 16'd1;
            end
            case (state_r)
                TX_IDLE: begin
                    if (rd_valid_i) begin
                        cfg_r         <= config_i;
                        shift_r       <= rd_data_i;
                        par_bit_r     <= (^rd_data_i) ^ (config_i.parity == uart_pkg::PARITY_ODD);
                        cnt_r         <= config_i.divisor - 16'd1;
                        second_stop_r <= 1'b0;
                        txd_o         <= 1'b0;
                        state_r       <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end_w) begin
                        txd_o     <= shift_r[0];
                        shift_r   <= shift_r >> 1;
                        bit_idx_r <= '0;
                        cnt_r     <= cfg_r.divisor - 16'd1;
                        state_r   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end_w) begin
                        cnt_r <= cfg_r.divisor - 16'd1;
                        if (bit_idx_r != 3'd7) begin
                            txd_o     <= shift_r[0];
                            shift_r   <= shift_r >> 1;
                            bit_idx_r <= bit_idx_r + 3'd1;
                        end else if (cfg_r.parity != uart_pkg::PARITY_NONE) begin
                            txd_o   <= par_bit_r;
                            state_r <= TX_PARITY;
                        end else begin
                            txd_o   <= 1'b1;
                            state_r <= TX_STOP;
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_end_w) begin
                        txd_o   <= 1'b1;
                        cnt_r   <= cfg_r.divisor - 16'd1;
                        state_r <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    if (bit_end_w) begin
                        if (cfg_r.stop_two && !second_stop_r) begin
                            second_stop_r <= 1'b1;
                            cnt_r         <= cfg_r.divisor - 16'd1;
                        end else begin
                            state_r <= TX_IDLE;
                        end
                    end
                end
                default: state_r <= TX_IDLE;
            endcase
        end
    end

endmodule

/* src/uart_regs.sv */
`timescale 1ns/100ps

module uart_regs #(
    parameter int unsigned RESET_DIVISOR = 434
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::wb_req_t      wb_req_i,
    output uart_pkg::wb_rsp_t      wb_rsp_o,
    output uart_pkg::uart_config_u config_o,
    output logic                   rx_rd_en_o,
    input  logic [7:0]             rx_data_i,
    input  logic                   rx_valid_i,
    input  logic                   rx_empty_i,
    output logic                   tx_wr_en_o,
    output logic [7:0]             tx_wr_data_o,
    input  logic                   tx_full_i,
    input  logic                   parity_err_i
);

    // One-hot register selects and the access direction
    typedef struct packed {
        logic cfg;
        logic rxdata;
        logic txstat;
        logic we;
    } bus_sel_t;

    localparam uart_pkg::uart_fields_t RESET_FIELDS = '{
        reserved: '0,
        stop_two: 1'b0,
        parity:   uart_pkg::PARITY_NONE,
        divisor:  16'(RESET_DIVISOR)
    };

    bus_sel_t               sel_w;
    bus_sel_t               sel_r;
    logic                   active_w;
    logic                   ack_r;
    logic                   parity_err_r;
    uart_pkg::uart_config_u config_r;
    uart_pkg::uart_config_u config_next_w;
    logic [31:0]            status_w;
    logic [31:0]            rd_data_w;

    // Held stb after ack is not a new access
    assign active_w = wb_req_i.cyc && wb_req_i.stb && !ack_r;

    always_comb begin
        sel_w = '0;
        if (active_w) begin
            sel_w.we = wb_req_i.we;
            case (wb_req_i.adr)
                uart_pkg::ADDR_CONFIG:        sel_w.cfg    = 1'b1;
                uart_pkg::ADDR_RXDATA:        sel_w.rxdata = 1'b1;
                uart_pkg::ADDR_TXDATA_STATUS: sel_w.txstat = 1'b1;
                default:                      sel_w        = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sel_r <= '0;
            ack_r <= 1'b0;
        end else begin
            sel_r <= sel_w;
            ack_r <= active_w;
        end
    end

    // Byte lanes on the raw view, reserved field forced back to zero
    always_comb begin
        config_next_w = config_r;
        for (int i = 0; i < 4; i++) begin
            if (wb_req_i.sel[i]) begin
                config_next_w.raw[8*i +: 8] = wb_req_i.dat[8*i +: 8];
            end
        end
        config_next_w.fields.reserved = '0;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            config_r.fields <= RESET_FIELDS;
        end else if (sel_w.cfg && sel_w.we) begin
            config_r <= config_next_w;
        end
    end

    // Sticky until a status read, a new error wins over the clear
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            parity_err_r <= 1'b0;
        end else if (parity_err_i) begin
            parity_err_r <= 1'b1;
        end else if (sel_r.txstat && !sel_r.we) begin
            parity_err_r <= 1'b0;
        end
    end

    always_comb begin
        status_w = '0;
        status_w[uart_pkg::STATUS_RX_EMPTY]   = rx_empty_i;
        status_w[uart_pkg::STATUS_TX_FULL]    = tx_full_i;
        status_w[uart_pkg::STATUS_PARITY_ERR] = parity_err_r;
    end

    always_comb begin
        rd_data_w = '0;
        if (!sel_r.we) begin
            if (sel_r.cfg) begin
                rd_data_w = config_r.raw;
            end else if (sel_r.rxdata) begin
                rd_data_w = {23'b0, rx_valid_i, rx_valid_i ? rx_data_i : 8'h00};
            end else if (sel_r.txstat) begin
                rd_data_w = status_w;
            end
        end
    end

    assign wb_rsp_o.ack = ack_r;
    assign wb_rsp_o.dat = rd_data_w;
    assign config_o     = config_r;

    // Pop in the request cycle so data is ready with ack
    assign rx_rd_en_o   = sel_w.rxdata && !sel_w.we;
    assign tx_wr_en_o   = sel_w.txstat && sel_w.we && wb_req_i.sel[0];
    assign tx_wr_data_o = wb_req_i.dat[7:0];

endmodule

/* src/uart_top.sv */
`timescale 1ns/100ps

module uart_top #(
    parameter int          FIFO_ADDR_WIDTH = 4,
    parameter int unsigned RESET_DIVISOR   = 434
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  uart_pkg::wb_req_t wb_req_i,
    output uart_pkg::wb_rsp_t wb_rsp_o,
    input  logic              rxd_i,
    output logic              txd_o,
    output logic              irq_o
);

    uart_pkg::uart_config_u config_w;

    logic       rx_byte_valid;
    logic [7:0] rx_byte;
    logic       rx_parity_err;
    logic       rx_rd_en;
    logic [7:0] rx_rd_data;
    logic       rx_rd_valid;
    logic       rx_empty;

    logic       tx_wr_en;
    logic [7:0] tx_wr_data;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_rd_en;
    logic [7:0] tx_rd_data;
    logic       tx_rd_valid;

    // Level interrupt while received data waits
    assign irq_o = !rx_empty;

    uart_regs #(
        .RESET_DIVISOR (RESET_DIVISOR)
    ) regs_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wb_req_i      (wb_req_i),
        .wb_rsp_o      (wb_rsp_o),
        .config_o      (config_w),
        .rx_rd_en_o    (rx_rd_en),
        .rx_data_i     (rx_rd_data),
        .rx_valid_i    (rx_rd_valid),
        .rx_empty_i    (rx_empty),
        .tx_wr_en_o    (tx_wr_en),
        .tx_wr_data_o  (tx_wr_data),
        .tx_full_i     (tx_full),
        .parity_err_i  (rx_parity_err)
    );

    uart_rx rx_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .config_i      (config_w.fields),
        .rxd_i         (rxd_i),
        .byte_o        (rx_byte),
        .byte_valid_o  (rx_byte_valid),
        .parity_err_o  (rx_parity_err)
    );

    uart_fifo #(
        .DATA_WIDTH (8),
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) rx_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (rx_byte_valid),
        .wr_data_i  (rx_byte),
        .rd_en_i    (rx_rd_en),
        .rd_data_o  (rx_rd_data),
        .rd_valid_o (rx_rd_valid),
        .empty_o    (rx_empty),
        .full_o     ()
    );

    // Transmitter polls while idle, the pop only reaches a non-empty FIFO
    uart_fifo #(
        .DATA_WIDTH (8),
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) tx_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (tx_wr_en),
        .wr_data_i  (tx_wr_data),
        .rd_en_i    (tx_rd_en && !tx_empty),
        .rd_data_o  (tx_rd_data),
        .rd_valid_o (tx_rd_valid),
        .empty_o    (tx_empty),
        .full_o     (tx_full)
    );

    uart_tx tx_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .config_i   (config_w.fields),
        .rd_en_o    (tx_rd_en),
        .rd_data_i  (tx_rd_data),
        .rd_valid_i (tx_rd_valid),
        .txd_o      (txd_o)
    );

endmodule

/* verification/uart_assertions.sv */
`timescale 1ns/100ps

module uart_assertions #(
    parameter int AW = 4
) (
    input logic              clk_i,
    input logic              rst_n_i,
    input uart_pkg::wb_req_t wb_req_i,
    input uart_pkg::wb_rsp_t wb_rsp_i,
    input logic              txd_i,
    input logic              irq_i,
    input logic [2:0]        tx_state_i,
    input logic [15:0]       tx_divisor_i,
    input logic              tx_wr_en_i,
    input logic              tx_full_i,
    input logic [AW:0]       tx_wr_ptr_i
);

    int          fail_count = 0;
    logic [15:0] since_start;

    // Cycles since the transmitter left idle (state 0)
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || tx_state_i == 3'd0) begin
            since_start <= '0;
        end else begin
            since_start <= since_start + 16'd1;
        end
    end

    ack_after_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_i.ack) |=> wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack did not follow an active request by one cycle");
        end

    ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack stayed high for two cycles");
        end

    reset_outputs: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (txd_i && !irq_i))
        else begin
            fail_count++;
            $error("txd not high or irq not low after reset");
        end

    txd_bit_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tx_state_i != 3'd0 && $changed(txd_i)) |-> (since_start % tx_divisor_i == 16'd0))
        else begin
            fail_count++;
            $error("txd changed off a bit boundary");
        end

    full_write_dropped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tx_wr_en_i && tx_full_i) |=> $stable(tx_wr_ptr_i))
        else begin
            fail_count++;
            $error("write into a full transmit FIFO was stored");
        end

endmodule

bind uart_top uart_assertions #(.AW(FIFO_ADDR_WIDTH)) assertions_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wb_req_i     (wb_req_i),
    .wb_rsp_i     (wb_rsp_o),
    .txd_i        (txd_o),
    .irq_i        (irq_o),
    .tx_state_i   (tx_i.state_r),
    .tx_divisor_i (tx_i.cfg_r.divisor),
    .tx_wr_en_i   (tx_wr_en),
    .tx_full_i    (tx_full),
    .tx_wr_ptr_i  (tx_fifo.wr_ptr)
);

/* verification/uart_tb.sv */
`timescale 1ns/100ps

module uart_tb;

    localparam int DIVISOR     = 8;
    localparam int FRAMES      = 25;
    localparam int CYCLE_LIMIT = FRAMES * 12 * DIVISOR + 2000;

    logic              clk_i;
    logic              rst_n_i;
    uart_pkg::wb_req_t wb_req;
    uart_pkg::wb_rsp_t wb_rsp;
    logic              rxd;
    logic              rxd_drv;
    logic              loopback;
    logic              txd;
    logic              irq;
    int                errors = 0;
    int                cycles = 0;
    logic [31:0]       lfsr;
    logic [7:0]        expected_q[$];

    assign rxd = loopback ? txd : rxd_drv;

    uart_top #(
        .FIFO_ADDR_WIDTH (2),
        .RESET_DIVISOR   (434)
    ) uart_top_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .rxd_i    (rxd),
        .txd_o    (txd),
        .irq_o    (irq)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT never answered", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Divisor in bits 15 to 0, parity in 17 to 16 and stop_two in 18
    function automatic logic [31:0] cfg_word(input uart_pkg::uart_parity_e par,
                                             input logic stop_two, input logic [15:0] div);
        return {13'b0, stop_two, par, div};
    endfunction

    function automatic logic [31:0] status_word(input logic rx_empty, input logic tx_full,
                                                input logic perr);
        logic [31:0] w;
        w = '0;
        w[uart_pkg::STATUS_RX_EMPTY]   = rx_empty;
        w[uart_pkg::STATUS_TX_FULL]    = tx_full;
        w[uart_pkg::STATUS_PARITY_ERR] = perr;
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat, output logic [31:0] rdata);
        @(posedge clk_i);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
        @(negedge clk_i);
        while (!wb_rsp.ack) @(negedge clk_i);
        rdata = wb_rsp.dat;
        @(posedge clk_i);
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [3:0] sel, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, sel, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] rdata);
        wb_access(1'b0, adr, 4'hf, 32'h0, rdata);
    endtask

    task automatic send_bit(input logic b);
        @(posedge clk_i);
        rxd_drv <= b;
        repeat (DIVISOR - 1) @(posedge clk_i);
    endtask

    task automatic serial_send(input logic [7:0] data, input uart_pkg::uart_parity_e par,
                               input logic stop_two, input logic bad_parity);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(data[i]);
        end
        if (par != uart_pkg::PARITY_NONE) begin
            send_bit((^data) ^ (par == uart_pkg::PARITY_ODD) ^ bad_parity);
        end
        send_bit(1'b1);
        if (stop_two) begin
            send_bit(1'b1);
        end
    endtask

    task automatic wait_irq();
        @(negedge clk_i);
        while (!irq) @(negedge clk_i);
    endtask

    // Pops the oldest expected byte and compares it with a receive read
    task automatic read_expect(input string name);
        logic [31:0] rd;
        logic [7:0]  exp;
        exp = expected_q.pop_front();
        wb_read(uart_pkg::ADDR_RXDATA, rd);
        check(name, {23'b0, 1'b1, exp}, rd);
    endtask

    initial begin
        logic [31:0] rd;
        logic [7:0]  b;
        lfsr     = 32'h5dfe;
        wb_req   = '0;
        rxd_drv  = 1'b1;
        loopback = 1'b0;
        rst_n_i  = 1'b0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        wb_read(uart_pkg::ADDR_CONFIG, rd);
        check("reset_config", cfg_word(uart_pkg::PARITY_NONE, 1'b0, 16'd434), rd);
        wb_read(uart_pkg::ADDR_TXDATA_STATUS, rd);
        check("reset_status", status_word(1'b1, 1'b0, 1'b0), rd);
        @(negedge clk_i);
        check("reset_irq", 32'd0, {31'b0, irq});

        // Divisor lanes only and then the field byte with reserved bits set
        wb_write(uart_pkg::ADDR_CONFIG, 4'b0011, 32'hffff_0008);
        wb_read(uart_pkg::ADDR_CONFIG, rd);
        check("lane_divisor", cfg_word(uart_pkg::PARITY_NONE, 1'b0, 16'd8), rd);
        wb_write(uart_pkg::ADDR_CONFIG, 4'b0100, 32'h00fd_0000);
        wb_read(uart_pkg::ADDR_CONFIG, rd);
        check("lane_fields", cfg_word(uart_pkg::PARITY_EVEN, 1'b1, 16'd8), rd);

        @(posedge clk_i);
        loopback <= 1'b1;
        for (int p = 0; p < 3; p++) begin
            for (int s = 0; s < 2; s++) begin
                wb_write(uart_pkg::ADDR_CONFIG, 4'b0111,
                         cfg_word(uart_pkg::uart_parity_e'(p), s[0], 16'(DIVISOR)));
                repeat (2) begin
                    next_byte(b);
                    expected_q.push_back(b);
                    wb_write(uart_pkg::ADDR_TXDATA_STATUS, 4'b0001, {24'b0, b});
                end
                repeat (2) begin
                    wait_irq();
                    read_expect("loopback_data");
                end
                @(negedge clk_i);
                check("loopback_irq_clear", 32'd0, {31'b0, irq});
            end
        end

        // Wrong parity bit from the serial driver
        @(posedge clk_i);
        loopback <= 1'b0;
        wb_write(uart_pkg::ADDR_CONFIG, 4'b0111,
                 cfg_word(uart_pkg::PARITY_EVEN, 1'b0, 16'(DIVISOR)));
        next_byte(b);
        serial_send(b, uart_pkg::PARITY_EVEN, 1'b0, 1'b1);
        repeat (DIVISOR) @(posedge clk_i);
        wb_read(uart_pkg::ADDR_TXDATA_STATUS, rd);
        check("parity_err_set", status_word(1'b1, 1'b0, 1'b1), rd);
        wb_read(uart_pkg::ADDR_TXDATA_STATUS, rd);
        check("parity_err_clear", status_word(1'b1, 1'b0, 1'b0), rd);

        // Six frames into a four deep receive FIFO
        wb_write(uart_pkg::ADDR_CONFIG, 4'b0111,
                 cfg_word(uart_pkg::PARITY_NONE, 1'b0, 16'(DIVISOR)));
        for (int i = 0; i < 6; i++) begin
            next_byte(b);
            if (i < 4) begin
                expected_q.push_back(b);
            end
            serial_send(b, uart_pkg::PARITY_NONE, 1'b0, 1'b0);
        end
        repeat (DIVISOR) @(posedge clk_i);
        repeat (4) read_expect("rx_overflow_data");
        wb_read(uart_pkg::ADDR_RXDATA, rd);
        check("rx_empty_read", 32'd0, rd);
        @(negedge clk_i);
        check("rx_empty_irq", 32'd0, {31'b0, irq});

        // Six writes while the first frame is on the line
        @(posedge clk_i);
        loopback <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            next_byte(b);
            if (i < 5) begin
                expected_q.push_back(b);
            end
            wb_write(uart_pkg::ADDR_TXDATA_STATUS, 4'b0001, {24'b0, b});
            if (i == 4) begin
                wb_read(uart_pkg::ADDR_TXDATA_STATUS, rd);
                check("tx_full_status", status_word(1'b1, 1'b1, 1'b0), rd);
            end
        end
        repeat (5) begin
            wait_irq();
            read_expect("tx_overflow_data");
        end
        repeat (12 * DIVISOR) @(negedge clk_i);
        check("tx_dropped_byte", 32'd0, {31'b0, irq});

        errors += uart_top_i.assertions_i.fail_count;
        $display("Run finished with %0d errors after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* build.f */
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_regs.sv
src/uart_top.sv
verification/uart_assertions.sv
verification/uart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f build.f --top-module uart_tb -o uart_sim \
    && ./obj_dir/uart_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
